//--- source/host_mem_pkg.sv
// Host memory package: line address and data types plus the read request and response channels
package host_mem_pkg;

    // ==================================================
    // Channel field widths
    // ==================================================

    // Addresses count lines, not bytes
    localparam int LINE_ADDR_W = 32;
    localparam int LINE_DATA_W = 128;

    // Burst length in beats
    localparam int BURST_LEN_W = 8;

    // Read id, wraps every 16 bursts
    localparam int RID_W = 4;

    typedef logic [LINE_ADDR_W-1:0] line_addr_t;
    typedef logic [LINE_DATA_W-1:0] line_data_t;
    typedef logic [BURST_LEN_W-1:0] burst_len_t;
    typedef logic [RID_W-1:0]       rid_t;

    // ==================================================
    // Channel payloads
    // ==================================================

    // Read request, len holds beats minus one
    typedef struct packed {
        line_addr_t addr;
        burst_len_t len;
        rid_t       id;
    } rd_req_t;

    // Read response beat
    typedef struct packed {
        line_data_t data;
        rid_t       id;
        logic       last;
    } rd_resp_t;

endpackage

//--- source/engine_cfg_pkg.sv
// Engine configuration package: register indices, field widths and the read setup struct
package engine_cfg_pkg;

    // ==================================================
    // Register port widths
    // ==================================================
    localparam int CSR_IDX_W  = 4;
    localparam int CSR_DATA_W = 64;

    typedef logic [CSR_IDX_W-1:0]  csr_idx_t;
    typedef logic [CSR_DATA_W-1:0] csr_data_t;

    // Write indices, gaps in the numbering are unused
    localparam csr_idx_t CSR_RD_BASE    = 4'd0;
    localparam csr_idx_t CSR_RD_CTRL    = 4'd2;
    localparam csr_idx_t CSR_ADDR_MASK  = 4'd4;
    localparam csr_idx_t CSR_READY_MASK = 4'd5;

    // Read indices, any other index reads as zero
    localparam csr_idx_t STAT_CONFIG         = 4'd0;
    localparam csr_idx_t STAT_RD_BURSTS_REQ  = 4'd1;
    localparam csr_idx_t STAT_RD_LINES_RESP  = 4'd2;
    localparam csr_idx_t STAT_RD_SUM         = 4'd5;
    localparam csr_idx_t STAT_RD_BURSTS_RESP = 4'd6;

    // ==================================================
    // Field widths and codes
    // ==================================================
    localparam int ADDR_LOW_W   = 16;
    localparam int NUM_BURSTS_W = 16;
    localparam int COUNTER_W    = 48;
    localparam int SUM_W        = 32;
    localparam int READY_MASK_W = 32;

    // Engine type code in the status word
    localparam logic [2:0] ENGINE_TYPE_RD = 3'd2;

    typedef logic [ADDR_LOW_W-1:0]   addr_low_t;
    typedef logic [NUM_BURSTS_W-1:0] num_bursts_t;
    typedef logic [COUNTER_W-1:0]    counter_t;
    typedef logic [SUM_W-1:0]        sum_t;
    typedef logic [READY_MASK_W-1:0] ready_mask_t;

    // Decoded read setup, shared by generator and monitor
    typedef struct packed {
        host_mem_pkg::line_addr_t base_addr;
        addr_low_t                start_low;
        host_mem_pkg::burst_len_t burst_len;
        num_bursts_t              num_bursts;
        addr_low_t                addr_mask;
        ready_mask_t              ready_mask;
    } rd_cfg_t;

endpackage

//--- source/engine_csr_regs.sv
// Engine registers: software writes, decode into the read setup and the status read mux
module engine_csr_regs
(
    input  logic                        clk,
    input  logic                        state_reset,

    // Register write port
    input  logic                        csr_wr_en,
    input  engine_cfg_pkg::csr_idx_t    csr_wr_idx,
    input  engine_cfg_pkg::csr_data_t   csr_wr_data,

    // Status read port
    input  engine_cfg_pkg::csr_idx_t    csr_rd_idx,
    output engine_cfg_pkg::csr_data_t   csr_rd_data,

    // Engine state for the status word
    input  logic                        run_q,
    input  logic                        clear_q,
    input  logic                        active,

    // Traffic counters and line sum
    input  engine_cfg_pkg::counter_t    rd_bursts_req,
    input  engine_cfg_pkg::counter_t    rd_lines_resp,
    input  engine_cfg_pkg::counter_t    rd_bursts_resp,
    input  engine_cfg_pkg::sum_t        rd_sum,

    // Decoded read setup
    output engine_cfg_pkg::rd_cfg_t     cfg
);

    // Largest burst length the len field can express
    localparam logic [14:0] MAX_BURST = 15'((1 << host_mem_pkg::BURST_LEN_W) - 1);

    engine_cfg_pkg::csr_data_t status_word;

    // ==================================================
    // Register writes
    // ==================================================
    always_ff @(posedge clk)
    begin
        if (state_reset)
        begin
            cfg <= '0;
            // Ready on every cycle until software says otherwise
            cfg.ready_mask <= '1;
        end
        else if (csr_wr_en)
        begin
            case (csr_wr_idx)
                engine_cfg_pkg::CSR_RD_BASE:
                    cfg.base_addr <= host_mem_pkg::line_addr_t'(csr_wr_data);
                engine_cfg_pkg::CSR_RD_CTRL:
                begin
                    // Split the control word into its three fields
                    cfg.num_bursts <= csr_wr_data[47:32];
                    cfg.start_low  <= csr_wr_data[31:16];
                    cfg.burst_len  <= host_mem_pkg::burst_len_t'(csr_wr_data[15:0]);
                end
                engine_cfg_pkg::CSR_ADDR_MASK:
                    cfg.addr_mask <= engine_cfg_pkg::addr_low_t'(csr_wr_data);
                engine_cfg_pkg::CSR_READY_MASK:
                    // Only the R channel half is kept
                    cfg.ready_mask <= engine_cfg_pkg::ready_mask_t'(csr_wr_data);
                default:
                    ;
            endcase
        end
    end

    // ==================================================
    // Status reads
    // ==================================================

    // Engine description and live state bits
    assign status_word = {26'h0,
                          engine_cfg_pkg::ENGINE_TYPE_RD,
                          active,
                          run_q,
                          clear_q,
                          16'(engine_cfg_pkg::ADDR_LOW_W),
                          1'b0,
                          MAX_BURST};

    always_comb
    begin
        case (csr_rd_idx)
            engine_cfg_pkg::STAT_CONFIG:         csr_rd_data = status_word;
            engine_cfg_pkg::STAT_RD_BURSTS_REQ:  csr_rd_data = 64'(rd_bursts_req);
            engine_cfg_pkg::STAT_RD_LINES_RESP:  csr_rd_data = 64'(rd_lines_resp);
            // Sum sits in the upper word, lower word unused
            engine_cfg_pkg::STAT_RD_SUM:         csr_rd_data = {rd_sum, 32'h0};
            engine_cfg_pkg::STAT_RD_BURSTS_RESP: csr_rd_data = 64'(rd_bursts_resp);
            default:                             csr_rd_data = '0;
        endcase
    end

endmodule

//--- source/rd_burst_gen.sv
// Read burst generator: issues masked, incrementing burst requests with rolling ids
module rd_burst_gen
(
    input  logic                        clk,
    input  logic                        state_reset,

    // Read setup from the registers
    input  engine_cfg_pkg::rd_cfg_t     cfg,

    // Registered engine controls
    input  logic                        run_q,
    input  logic                        clear_q,

    // Request channel
    output logic                        ar_valid,
    output host_mem_pkg::rd_req_t       ar,
    input  logic                        ar_ready,

    // No more requests in this run
    output logic                        done
);

    // Low offset, ORed into the base after masking
    engine_cfg_pkg::addr_low_t   cur_low;
    host_mem_pkg::rid_t          rd_id;
    engine_cfg_pkg::num_bursts_t bursts_left;
    // Zero burst count means run forever
    logic                        unlimited;
    logic                        ar_fire;

    // ==================================================
    // Request channel
    // ==================================================

    // Valid never looks at ready
    assign ar_valid = run_q && !done;
    assign ar_fire  = ar_valid && ar_ready;

    always_comb
    begin
        // Base is aligned to the mask so OR replaces an add
        ar.addr = cfg.base_addr |
                  host_mem_pkg::line_addr_t'(cur_low & cfg.addr_mask);
        ar.len  = cfg.burst_len - host_mem_pkg::burst_len_t'(1);
        ar.id   = rd_id;
    end

    // ==================================================
    // Burst tracking
    // ==================================================
    always_ff @(posedge clk)
    begin
        if (state_reset)
        begin
            cur_low     <= '0;
            rd_id       <= '0;
            bursts_left <= '0;
            unlimited   <= 1'b0;
            // Idle until the first clear
            done        <= 1'b1;
        end
        else if (clear_q)
        begin
            cur_low     <= cfg.start_low;
            rd_id       <= '0;
            bursts_left <= cfg.num_bursts;
            unlimited   <= (cfg.num_bursts == '0);
            // A zero base disables the engine
            done        <= (cfg.base_addr == '0);
        end
        else if (ar_fire)
        begin
            // Step one burst forward
            cur_low     <= cur_low + engine_cfg_pkg::addr_low_t'(cfg.burst_len);
            rd_id       <= rd_id + host_mem_pkg::rid_t'(1);
            bursts_left <= bursts_left - engine_cfg_pkg::num_bursts_t'(1);
            // Last one of a bounded run
            done        <= !unlimited && (bursts_left == engine_cfg_pkg::num_bursts_t'(1));
        end
    end

endmodule

//--- source/rd_resp_monitor.sv
// Read response monitor: rotating ready mask, line sum and the request and response counters
module rd_resp_monitor
(
    input  logic                        clk,
    input  logic                        state_reset,

    // Read setup and registered clear
    input  engine_cfg_pkg::rd_cfg_t     cfg,
    input  logic                        clear_q,

    // Accepted request seen on the request channel
    input  logic                        ar_fire,

    // Response channel
    input  logic                        r_valid,
    input  host_mem_pkg::rd_resp_t      r,
    output logic                        r_ready,

    // Traffic counters and line sum
    output engine_cfg_pkg::counter_t    rd_bursts_req,
    output engine_cfg_pkg::counter_t    rd_lines_resp,
    output engine_cfg_pkg::counter_t    rd_bursts_resp,
    output engine_cfg_pkg::sum_t        rd_sum,

    // Requested bursts still waiting for their last beat
    output logic                        outstanding
);

    engine_cfg_pkg::ready_mask_t ready_mask_q;
    engine_cfg_pkg::sum_t        line_part;
    logic                        r_fire;

    // ==================================================
    // Ready mask
    // ==================================================

    // Bit 0 is this cycle's ready
    assign r_ready = ready_mask_q[0];
    assign r_fire  = r_valid && r_ready;

    always_ff @(posedge clk)
    begin
        if (state_reset)
            ready_mask_q <= '1;
        else if (clear_q)
            ready_mask_q <= cfg.ready_mask;
        else
            // Rotate right by one each cycle
            ready_mask_q <= {ready_mask_q[0], ready_mask_q[engine_cfg_pkg::READY_MASK_W-1:1]};
    end

    // ==================================================
    // Counters and sum
    // ==================================================

    // Top and bottom 16 bits of the line
    assign line_part = {r.data[host_mem_pkg::LINE_DATA_W-1 -: 16], r.data[15:0]};

    always_ff @(posedge clk)
    begin
        if (state_reset || clear_q)
        begin
            rd_bursts_req  <= '0;
            rd_lines_resp  <= '0;
            rd_bursts_resp <= '0;
            rd_sum         <= '0;
        end
        else
        begin
            if (ar_fire)
                rd_bursts_req <= rd_bursts_req + engine_cfg_pkg::counter_t'(1);

            if (r_fire)
            begin
                rd_lines_resp <= rd_lines_resp + engine_cfg_pkg::counter_t'(1);
                // Order-free check value
                rd_sum        <= rd_sum + line_part;
            end

            // Bursts end on the last flag
            if (r_fire && r.last)
                rd_bursts_resp <= rd_bursts_resp + engine_cfg_pkg::counter_t'(1);
        end
    end

    assign outstanding = (rd_bursts_req != rd_bursts_resp);

endmodule

//--- source/host_mem_rd_engine.sv
// Host memory read engine top: registers, burst generator and response monitor
module host_mem_rd_engine
(
    input  logic                        clk,
    input  logic                        state_reset,

    // Register write port
    input  logic                        csr_wr_en,
    input  engine_cfg_pkg::csr_idx_t    csr_wr_idx,
    input  engine_cfg_pkg::csr_data_t   csr_wr_data,

    // Status read port, combinational
    input  engine_cfg_pkg::csr_idx_t    csr_rd_idx,
    output engine_cfg_pkg::csr_data_t   csr_rd_data,

    // Engine control levels
    input  logic                        run,
    input  logic                        clear,

    // Request channel
    output logic                        ar_valid,
    output host_mem_pkg::rd_req_t       ar,
    input  logic                        ar_ready,

    // Response channel
    input  logic                        r_valid,
    input  host_mem_pkg::rd_resp_t      r,
    output logic                        r_ready,

    output logic                        active
);

    logic                      run_q;
    logic                      clear_q;
    logic                      done;
    logic                      outstanding;
    logic                      ar_fire;
    engine_cfg_pkg::rd_cfg_t   cfg;
    engine_cfg_pkg::counter_t  rd_bursts_req;
    engine_cfg_pkg::counter_t  rd_lines_resp;
    engine_cfg_pkg::counter_t  rd_bursts_resp;
    engine_cfg_pkg::sum_t      rd_sum;

    // ==================================================
    // Control registers and engine state
    // ==================================================
    always_ff @(posedge clk)
    begin
        if (state_reset)
        begin
            run_q   <= 1'b0;
            clear_q <= 1'b0;
            active  <= 1'b0;
        end
        else
        begin
            run_q   <= run;
            clear_q <= clear;
            // Busy while issuing or while bursts are in flight
            active  <= (run_q && !done) || outstanding;
        end
    end

    assign ar_fire = ar_valid && ar_ready;

    // ==================================================
    // Blocks
    // ==================================================
    engine_csr_regs u_csr_regs
    (
        .clk            (clk),
        .state_reset    (state_reset),
        .csr_wr_en      (csr_wr_en),
        .csr_wr_idx     (csr_wr_idx),
        .csr_wr_data    (csr_wr_data),
        .csr_rd_idx     (csr_rd_idx),
        .csr_rd_data    (csr_rd_data),
        .run_q          (run_q),
        .clear_q        (clear_q),
        .active         (active),
        .rd_bursts_req  (rd_bursts_req),
        .rd_lines_resp  (rd_lines_resp),
        .rd_bursts_resp (rd_bursts_resp),
        .rd_sum         (rd_sum),
        .cfg            (cfg)
    );

    rd_burst_gen u_burst_gen
    (
        .clk         (clk),
        .state_reset (state_reset),
        .cfg         (cfg),
        .run_q       (run_q),
        .clear_q     (clear_q),
        .ar_valid    (ar_valid),
        .ar          (ar),
        .ar_ready    (ar_ready),
        .done        (done)
    );

    rd_resp_monitor u_resp_monitor
    (
        .clk            (clk),
        .state_reset    (state_reset),
        .cfg            (cfg),
        .clear_q        (clear_q),
        .ar_fire        (ar_fire),
        .r_valid        (r_valid),
        .r              (r),
        .r_ready        (r_ready),
        .rd_bursts_req  (rd_bursts_req),
        .rd_lines_resp  (rd_lines_resp),
        .rd_bursts_resp (rd_bursts_resp),
        .rd_sum         (rd_sum),
        .outstanding    (outstanding)
    );

endmodule

//--- dv/tb_clock_gen.sv
// Testbench clock and reset source: 4 ns clock, state_reset held for the first 5 cycles
module tb_clock_gen
(
    output logic clk,
    output logic state_reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;
    end

    // Release on a falling edge so the first active edge sees a clean level
    initial
    begin
        state_reset = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        state_reset = 1'b0;
    end

endmodule

//--- dv/host_mem_rd_engine_properties.sv
// Read engine channel properties: request stability, ready mask rotation and reset state
module host_mem_rd_engine_properties
(
    input logic                        clk,
    input logic                        state_reset,
    input logic                        clear_q,
    input logic                        ar_valid,
    input host_mem_pkg::rd_req_t       ar,
    input logic                        ar_ready,
    input logic                        r_ready,
    input engine_cfg_pkg::ready_mask_t ready_mask_q
);
    timeunit 1ns;
    timeprecision 100ps;

    // A stalled request keeps its payload
    ar_stable_while_stalled: assert property (@(posedge clk) disable iff (state_reset)
        (ar_valid && !ar_ready) |=> $stable(ar))
    else
        $error("ar changed while ar_valid was high and ar_ready low");

    // Outside clear the ready bit walks down the mask one place per cycle
    r_ready_rotates: assert property (@(posedge clk) disable iff (state_reset)
        !clear_q |=> (r_ready == $past(ready_mask_q[1])))
    else
        $error("r_ready does not follow the rotating ready mask");

    // No request comes out of reset
    ar_idle_after_reset: assert property (@(posedge clk)
        state_reset |=> !ar_valid)
    else
        $error("ar_valid high right after state_reset");

endmodule

bind host_mem_rd_engine host_mem_rd_engine_properties u_props
(
    .clk          (clk),
    .state_reset  (state_reset),
    .clear_q      (clear_q),
    .ar_valid     (ar_valid),
    .ar           (ar),
    .ar_ready     (ar_ready),
    .r_ready      (r_ready),
    .ready_mask_q (u_resp_monitor.ready_mask_q)
);

//--- dv/host_mem_rd_engine_tb.sv
// Read engine testbench: memory responder model, random handshakes and register checks
module host_mem_rd_engine_tb;
    timeunit 1ns;
    timeprecision 100ps;

    // ==================================================
    // Test setup
    // ==================================================
    localparam logic [31:0] BASE_A  = 32'h0010_0000;
    localparam logic [15:0] START_A = 16'hFFF0;
    localparam int          BL_A    = 4;
    localparam int          N_A     = 12;
    localparam logic [31:0] BASE_B  = 32'h2000_0000;
    localparam logic [15:0] START_B = 16'h0100;
    localparam int          BL_B    = 8;
    localparam int          N_B     = 6;
    // Four cycles per configured beat plus setup margin
    localparam int CYCLE_LIMIT = 4 * (N_A * BL_A + N_B * BL_B) + 200;

    logic                        clk;
    logic                        state_reset;
    logic                        csr_wr_en;
    engine_cfg_pkg::csr_idx_t    csr_wr_idx;
    engine_cfg_pkg::csr_data_t   csr_wr_data;
    engine_cfg_pkg::csr_idx_t    csr_rd_idx;
    engine_cfg_pkg::csr_data_t   csr_rd_data;
    logic                        run;
    logic                        clear;
    logic                        ar_valid;
    host_mem_pkg::rd_req_t       ar;
    logic                        ar_ready;
    logic                        r_valid;
    host_mem_pkg::rd_resp_t      r;
    logic                        r_ready;
    logic                        active;

    // Model state
    integer      seed = 32'h887e8fe0;
    int          cycle_cnt = 0;
    int          error_cnt;
    int          tests_run;
    int          tests_failed;
    logic [31:0] exp_base;
    logic [15:0] exp_start;
    logic [15:0] exp_mask;
    int          exp_blen;
    logic [31:0] ready_cfg_m = '1;
    logic [31:0] mask_m;
    logic        clear_q_m;
    int          req_cnt;
    int          lines_m;
    logic [31:0] sum_m;
    logic [31:0] req_addr_q[$];
    int          req_len_q[$];
    logic [3:0]  req_id_q[$];
    logic        burst_open;
    logic        fired_last;
    int          beat_idx;
    logic [31:0] cur_addr;
    int          cur_len;
    logic [3:0]  cur_id;

    tb_clock_gen u_clock_gen
    (
        .clk         (clk),
        .state_reset (state_reset)
    );

    host_mem_rd_engine dut
    (
        .clk         (clk),
        .state_reset (state_reset),
        .csr_wr_en   (csr_wr_en),
        .csr_wr_idx  (csr_wr_idx),
        .csr_wr_data (csr_wr_data),
        .csr_rd_idx  (csr_rd_idx),
        .csr_rd_data (csr_rd_data),
        .run         (run),
        .clear       (clear),
        .ar_valid    (ar_valid),
        .ar          (ar),
        .ar_ready    (ar_ready),
        .r_valid     (r_valid),
        .r           (r),
        .r_ready     (r_ready),
        .active      (active)
    );

    task automatic report_error(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        error_cnt++;
    endtask

    // Address of the kth request: base ORed with the masked, wrapped offset
    function automatic logic [31:0] expected_addr(input int k);
        logic [15:0] offset;
        offset = 16'(int'(exp_start) + k * exp_blen);
        return exp_base | {16'h0, offset & exp_mask};
    endfunction

    // ==================================================
    // Ready mask model, follows the registered clear
    // ==================================================
    always @(posedge clk)
    begin
        if (state_reset)
        begin
            mask_m    <= '1;
            clear_q_m <= 1'b0;
        end
        else
        begin
            mask_m    <= clear_q_m ? ready_cfg_m : {mask_m[0], mask_m[31:1]};
            clear_q_m <= clear;
        end
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT)
        begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // ==================================================
    // Memory responder, works on the falling edge
    // ==================================================
    always @(negedge clk)
    begin
        if (!state_reset)
        begin
            if (r_ready !== mask_m[0])
                report_error($sformatf("r_ready %b, mask model expects %b", r_ready, mask_m[0]));

            // Request side, the transfer happens at the next rising edge
            ar_ready = ($random(seed) & 3) != 0;
            if (ar_valid && ar_ready)
            begin
                if (ar.addr !== expected_addr(req_cnt))
                    report_error($sformatf("request %0d addr %h, expected %h",
                                           req_cnt, ar.addr, expected_addr(req_cnt)));
                if (ar.id !== 4'(req_cnt % 16))
                    report_error($sformatf("request %0d id %0d", req_cnt, ar.id));
                if (int'(ar.len) != exp_blen - 1)
                    report_error($sformatf("request %0d len %0d", req_cnt, ar.len));
                req_addr_q.push_back(ar.addr);
                req_len_q.push_back(int'(ar.len));
                req_id_q.push_back(ar.id);
                req_cnt++;
            end

            // Response side, an unaccepted beat stays on the bus
            if (fired_last)
                r_valid = 1'b0;
            if (!r_valid)
            begin
                if (!burst_open && req_addr_q.size() > 0)
                begin
                    cur_addr   = req_addr_q.pop_front();
                    cur_len    = req_len_q.pop_front();
                    cur_id     = req_id_q.pop_front();
                    beat_idx   = 0;
                    burst_open = 1'b1;
                end
                if (burst_open && (($random(seed) & 7) != 0))
                begin
                    r.data  = {32'($random(seed)), cur_addr + 32'(beat_idx),
                               32'($random(seed)), 32'($random(seed))};
                    r.id    = cur_id;
                    r.last  = (beat_idx == cur_len);
                    r_valid = 1'b1;
                end
            end
            fired_last = r_valid && r_ready;
            if (fired_last)
            begin
                sum_m = sum_m + {r.data[127:112], r.data[15:0]};
                lines_m++;
                beat_idx++;
                if (r.last)
                    burst_open = 1'b0;
            end
        end
    end

    // ==================================================
    // Register access and run control
    // ==================================================
    task automatic write_csr(input engine_cfg_pkg::csr_idx_t idx, input logic [63:0] data);
        csr_wr_en   = 1'b1;
        csr_wr_idx  = idx;
        csr_wr_data = data;
        @(negedge clk);
        csr_wr_en   = 1'b0;
    endtask

    // Combinational read, sampled well before the next rising edge
    task automatic read_csr(input engine_cfg_pkg::csr_idx_t idx, output logic [63:0] data);
        csr_rd_idx = idx;
        #1;
        data = csr_rd_data;
        @(negedge clk);
    endtask

    task automatic configure(input logic [31:0] base, input logic [15:0] start, input int blen,
                             input int n, input logic [15:0] amask, input logic [31:0] rmask);
        write_csr(engine_cfg_pkg::CSR_RD_BASE, 64'(base));
        write_csr(engine_cfg_pkg::CSR_RD_CTRL, {16'h0, 16'(n), start, 16'(blen)});
        write_csr(engine_cfg_pkg::CSR_ADDR_MASK, 64'(amask));
        write_csr(engine_cfg_pkg::CSR_READY_MASK, 64'(rmask));
        exp_base    = base;
        exp_start   = start;
        exp_blen    = blen;
        exp_mask    = amask;
        ready_cfg_m = rmask;
    endtask

    task automatic check_status(input logic run_exp, input logic clear_exp);
        logic [63:0] word;
        read_csr(engine_cfg_pkg::STAT_CONFIG, word);
        if (word[37:35] != 3'd2)
            report_error($sformatf("status engine type %0d", word[37:35]));
        if (word[33] != run_exp || word[32] != clear_exp)
            report_error($sformatf("status run %b clear %b", word[33], word[32]));
        if (word[31:16] != 16'd16)
            report_error($sformatf("status low width %0d", word[31:16]));
    endtask

    // Clear resets the model along with the engine
    task automatic clear_engine();
        clear   = 1'b1;
        req_cnt = 0;
        lines_m = 0;
        sum_m   = '0;
        @(negedge clk);
        @(negedge clk);
        check_status(1'b0, 1'b1);
        clear = 1'b0;
        @(negedge clk);
        @(negedge clk);
    endtask

    task automatic run_and_drain(input int n, input int blen);
        logic        active_seen;
        int          wait_cnt;
        logic [63:0] word;
        active_seen = 1'b0;
        run = 1'b1;
        repeat (4) @(negedge clk);
        check_status(1'b1, 1'b0);
        while (req_cnt < n || lines_m < n * blen)
        begin
            active_seen = active_seen | active;
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
        if (req_cnt != n || ar_valid)
            report_error($sformatf("%0d requests issued for a run of %0d", req_cnt, n));
        if (!active_seen)
            report_error("active never went high during the run");
        run = 1'b0;
        wait_cnt = 0;
        while (active && wait_cnt < 10)
        begin
            @(negedge clk);
            wait_cnt++;
        end
        if (active)
            $display("active is still high 10 cycles after the run drained");
        if (active)
            error_cnt++;
        read_csr(engine_cfg_pkg::STAT_RD_BURSTS_REQ, word);
        if (word != 64'(n))
            report_error($sformatf("bursts requested %0d, expected %0d", word, n));
        read_csr(engine_cfg_pkg::STAT_RD_BURSTS_RESP, word);
        if (word != 64'(n))
            report_error($sformatf("bursts returned %0d, expected %0d", word, n));
        read_csr(engine_cfg_pkg::STAT_RD_LINES_RESP, word);
        if (word != 64'(n * blen))
            report_error($sformatf("lines returned %0d, expected %0d", word, n * blen));
        read_csr(engine_cfg_pkg::STAT_RD_SUM, word);
        if (word[63:32] != sum_m)
            report_error($sformatf("sum %h, model %h", word[63:32], sum_m));
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (error_cnt == errors_before)
            $display("test %s: passed", name);
        else
        begin
            $display("test %s: failed with %0d errors", name, error_cnt - errors_before);
            tests_failed++;
        end
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    initial
    begin
        int errors_before;
        csr_wr_en   = 1'b0;
        csr_wr_idx  = '0;
        csr_wr_data = '0;
        csr_rd_idx  = '0;
        run         = 1'b0;
        clear       = 1'b0;
        ar_ready    = 1'b0;
        r_valid     = 1'b0;
        r           = '0;
        burst_open  = 1'b0;
        fired_last  = 1'b0;
        error_cnt   = 0;
        tests_run   = 0;
        tests_failed = 0;
        req_cnt     = 0;
        lines_m     = 0;
        sum_m       = '0;
        @(negedge state_reset);
        @(negedge clk);
        if (ar_valid)
            report_error("ar_valid high after state_reset");

        errors_before = error_cnt;
        check_status(1'b0, 1'b0);
        clear_engine();
        finish_test("status_word", errors_before);

        errors_before = error_cnt;
        configure(BASE_A, START_A, BL_A, N_A, 16'h00FF, 32'hFFFF_FFFF);
        clear_engine();
        run_and_drain(N_A, BL_A);
        finish_test("burst_run", errors_before);

        // Eight ready cycles out of every 32
        errors_before = error_cnt;
        configure(BASE_B, START_B, BL_B, N_B, 16'hFFFF, 32'h0000_00FF);
        clear_engine();
        run_and_drain(N_B, BL_B);
        finish_test("ready_mask", errors_before);

        errors_before = error_cnt;
        configure(32'h0, START_A, BL_A, N_A, 16'hFFFF, 32'hFFFF_FFFF);
        clear_engine();
        run = 1'b1;
        repeat (20)
        begin
            @(negedge clk);
            if (active || ar_valid)
                report_error("zero base engine became active");
        end
        run = 1'b0;
        if (req_cnt != 0)
            report_error($sformatf("zero base engine issued %0d requests", req_cnt));
        finish_test("zero_base", errors_before);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_cnt);
        if (error_cnt == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- build.f
source/host_mem_pkg.sv
source/engine_cfg_pkg.sv
source/engine_csr_regs.sv
source/rd_burst_gen.sv
source/rd_resp_monitor.sv
source/host_mem_rd_engine.sv
dv/tb_clock_gen.sv
dv/host_mem_rd_engine_properties.sv
dv/host_mem_rd_engine_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the read engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing \
    -f build.f \
    --top-module host_mem_rd_engine_tb \
    -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/Vhost_mem_rd_engine_tb > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^STATUS: PASS$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
